// File: hdl/bridge_pkg.sv
package bridge_pkg;

    // slow clock enable for the line bridges
    localparam int tick_div      = 9;               // clk cycles per enable pulse
    localparam int tick_cnt_bits = $clog2(tick_div);

    // line bridge FSM, remembers who pulled first
    typedef enum logic [1:0]
    {
        ls_idle,
        ls_a_holds,     // side a low, b mirrored
        ls_b_holds,     // side b low, a mirrored
        ls_release      // one enabled cycle for the mirrored side to float up
    } line_state_t;

    // record kinds in the event log
    typedef enum logic [1:0]
    {
        ev_start,
        ev_stop,
        ev_byte
    } event_kind_t;

    // record = {kind[15:14], ack[13], overflow[12], seq[11:8], data[7:0]}
    localparam int rec_width     = 16;
    localparam int rec_seq_bits  = 4;
    localparam int rec_data_bits = 8;

    // event memory and its bus
    localparam int ram_depth     = 64;
    localparam int ram_addr_bits = 6;
    localparam int wb_data_bits  = 16;

endpackage

// File: hdl/i2c_line_bridge.sv
`timescale 1ns/100ps

module i2c_line_bridge
(
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,    // shared slow enable
    input  logic a_in,      // pad level, side a
    input  logic b_in,      // pad level, side b
    output logic a_rel,     // 1 = released, 0 = pull low
    output logic b_rel
);
    import bridge_pkg::*;

    line_state_t state;

    // only the side that went low first is watched while holding,
    // the mirrored side would otherwise see its own low and stick
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ls_idle;
        end
        else if (clk_en)
        begin
            case (state)
                ls_idle:
                begin
                    if (!a_in)
                        state <= ls_a_holds;    // a wins a tie
                    else if (!b_in)
                        state <= ls_b_holds;
                end
                ls_a_holds:
                begin
                    if (a_in)
                        state <= ls_release;
                end
                ls_b_holds:
                begin
                    if (b_in)
                        state <= ls_release;
                end
                default:
                begin
                    state <= ls_idle;           // after one enabled cycle
                end
            endcase
        end
    end

    // drive the side opposite to the holder
    assign a_rel = (state != ls_b_holds);
    assign b_rel = (state != ls_a_holds);

endmodule

// File: hdl/i2c_bus_bridge.sv
`timescale 1ns/100ps

module i2c_bus_bridge
(
    input  logic clk,
    input  logic arst_n,
    input  logic sda_a_in,
    input  logic scl_a_in,
    input  logic sda_b_in,
    input  logic scl_b_in,
    output logic sda_a_rel,
    output logic scl_a_rel,
    output logic sda_b_rel,
    output logic scl_b_rel
);
    import bridge_pkg::*;

    logic [tick_cnt_bits-1:0] tick_cnt;
    logic                     clk_en;

    // free running divider, one pulse every tick_div clocks
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            tick_cnt <= '0;
        else if (clk_en)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign clk_en = (tick_cnt == tick_cnt_bits'(tick_div - 1));

    // sda and scl switch on the same enabled cycles
    i2c_line_bridge sda_bridge_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .a_in   (sda_a_in),
        .b_in   (sda_b_in),
        .a_rel  (sda_a_rel),
        .b_rel  (sda_b_rel)
    );

    i2c_line_bridge scl_bridge_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .a_in   (scl_a_in),
        .b_in   (scl_b_in),
        .a_rel  (scl_a_rel),
        .b_rel  (scl_b_rel)
    );

endmodule

// File: hdl/i2c_bus_monitor.sv
`timescale 1ns/100ps

module i2c_bus_monitor
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               sda_in,     // resolved side a level
    input  logic                               scl_in,
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic                               wb_we,
    output logic [bridge_pkg::ram_addr_bits-1:0] wb_adr,
    output logic [bridge_pkg::wb_data_bits-1:0]  wb_dat_w,
    input  logic                               wb_ack
);
    import bridge_pkg::*;

    logic [1:0]               sda_sync;     // [1] is the synchronized level
    logic [1:0]               scl_sync;
    logic                     sda_d;
    logic                     scl_d;
    logic                     start_det;
    logic                     stop_det;
    logic                     scl_rise;
    logic                     in_frame;
    logic [3:0]               bit_cnt;      // 0..7 data, 8 = ack slot
    logic [rec_data_bits-1:0] shreg;
    logic                     byte_done;
    logic                     ev_valid;
    event_kind_t              ev_kind;
    logic                     ev_ack;
    logic [rec_data_bits-1:0] ev_data;
    logic                     pend;         // one record waiting for the bus
    logic                     ovf;          // an event was dropped
    logic [rec_seq_bits-1:0]  seq;
    logic [ram_addr_bits-1:0] wr_ptr;
    logic [rec_width-1:0]     rec;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sda_sync <= 2'b11;  // idle bus is high
            scl_sync <= 2'b11;
            sda_d    <= 1'b1;
            scl_d    <= 1'b1;
        end
        else
        begin
            sda_sync <= {sda_sync[0], sda_in};
            scl_sync <= {scl_sync[0], scl_in};
            sda_d    <= sda_sync[1];
            scl_d    <= scl_sync[1];
        end
    end

    // sda may only move while scl is low, except for start and stop
    assign start_det = scl_sync[1] & scl_d & sda_d & ~sda_sync[1];
    assign stop_det  = scl_sync[1] & scl_d & ~sda_d & sda_sync[1];
    assign scl_rise  = scl_sync[1] & ~scl_d;
    assign byte_done = scl_rise & in_frame & (bit_cnt == 4'd8);

    // 8 data bits then the ack bit, msb first
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_frame <= 1'b0;
            bit_cnt  <= '0;
        end
        else if (start_det)
        begin
            in_frame <= 1'b1;   // repeated start restarts the count too
            bit_cnt  <= '0;
        end
        else if (stop_det)
        begin
            in_frame <= 1'b0;
        end
        else if (byte_done)
        begin
            bit_cnt <= '0;
        end
        else if (scl_rise && in_frame)
        begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (scl_rise && in_frame && bit_cnt < 4'd8)
            shreg <= {shreg[rec_data_bits-2:0], sda_sync[1]};
    end

    always_comb
    begin
        ev_valid = 1'b1;
        ev_kind  = ev_byte;
        ev_ack   = 1'b0;
        ev_data  = '0;
        if (start_det)
            ev_kind = ev_start;
        else if (stop_det)
            ev_kind = ev_stop;
        else if (byte_done)
        begin
            ev_ack  = sda_sync[1];  // low = acked, as on the wire
            ev_data = shreg;
        end
        else
            ev_valid = 1'b0;
    end

    // one pending record, later events are dropped and flagged
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pend   <= 1'b0;
            ovf    <= 1'b0;
            seq    <= '0;
            wr_ptr <= '0;
        end
        else
        begin
            if (pend && wb_ack)
            begin
                pend   <= 1'b0;             // cyc drops next cycle
                wr_ptr <= wr_ptr + 1'b1;    // wraps at ram_depth
            end
            if (ev_valid && !pend)
            begin
                pend <= 1'b1;
                ovf  <= 1'b0;               // reported in this record
                seq  <= seq + 1'b1;
            end
            else if (ev_valid)
            begin
                ovf <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ev_valid && !pend)
            rec <= {ev_kind, ev_ack, ovf, seq, ev_data};
    end

    assign wb_cyc   = pend;
    assign wb_stb   = pend;
    assign wb_we    = 1'b1;     // monitor only writes
    assign wb_adr   = wr_ptr;
    assign wb_dat_w = rec;

endmodule

// File: hdl/wb_arbiter.sv
`timescale 1ns/100ps

module wb_arbiter
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 m0_cyc,
    input  logic                                 m0_stb,
    input  logic                                 m0_we,
    input  logic [bridge_pkg::ram_addr_bits-1:0] m0_adr,
    input  logic [bridge_pkg::wb_data_bits-1:0]  m0_dat_w,
    output logic [bridge_pkg::wb_data_bits-1:0]  m0_dat_r,
    output logic                                 m0_ack,
    input  logic                                 m1_cyc,
    input  logic                                 m1_stb,
    input  logic                                 m1_we,
    input  logic [bridge_pkg::ram_addr_bits-1:0] m1_adr,
    input  logic [bridge_pkg::wb_data_bits-1:0]  m1_dat_w,
    output logic [bridge_pkg::wb_data_bits-1:0]  m1_dat_r,
    output logic                                 m1_ack,
    output logic                                 s_cyc,
    output logic                                 s_stb,
    output logic                                 s_we,
    output logic [bridge_pkg::ram_addr_bits-1:0] s_adr,
    output logic [bridge_pkg::wb_data_bits-1:0]  s_dat_w,
    input  logic [bridge_pkg::wb_data_bits-1:0]  s_dat_r,
    input  logic                                 s_ack
);
    typedef enum logic [1:0]
    {
        gnt_none,
        gnt_m0,
        gnt_m1
    } grant_t;

    grant_t gnt;
    logic   sel_m1;

    // idle grant decided combinationally so the first cycle is not lost
    assign sel_m1 = (gnt == gnt_m1) || (gnt == gnt_none && !m0_cyc && m1_cyc);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            gnt <= gnt_none;
        else
        begin
            case (gnt)
                gnt_none:
                begin
                    if (m0_cyc)
                        gnt <= gnt_m0;  // monitor wins ties
                    else if (m1_cyc)
                        gnt <= gnt_m1;
                end
                gnt_m0:  if (!m0_cyc) gnt <= gnt_none;
                gnt_m1:  if (!m1_cyc) gnt <= gnt_none;
                default: gnt <= gnt_none;
            endcase
        end
    end

    assign s_cyc   = sel_m1 ? m1_cyc   : m0_cyc;
    assign s_stb   = sel_m1 ? m1_stb   : m0_stb;
    assign s_we    = sel_m1 ? m1_we    : m0_we;
    assign s_adr   = sel_m1 ? m1_adr   : m0_adr;
    assign s_dat_w = sel_m1 ? m1_dat_w : m0_dat_w;

    // read data is shared, ack goes to the owner only
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m0_ack   = s_ack & ~sel_m1;
    assign m1_ack   = s_ack & sel_m1;

endmodule

// File: hdl/event_ram.sv
`timescale 1ns/100ps

module event_ram
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [bridge_pkg::ram_addr_bits-1:0] adr,
    input  logic [bridge_pkg::wb_data_bits-1:0]  dat_w,
    output logic [bridge_pkg::wb_data_bits-1:0]  dat_r,
    output logic                                 ack
);
    import bridge_pkg::*;

    logic [wb_data_bits-1:0] mem [ram_depth];
    logic                    access;

    // new access only when ack is low, so a held stb is not taken twice
    assign access = cyc & stb & ~ack;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ack <= 1'b0;
        else
            ack <= access;  // single cycle pulse
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            if (we)
                mem[adr] <= dat_w;
            dat_r <= mem[adr];  // old word on a write
        end
    end

endmodule

// File: hdl/i2c_bridge_top.sv
`timescale 1ns/100ps

module i2c_bridge_top
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 sda_a_in,
    input  logic                                 scl_a_in,
    input  logic                                 sda_b_in,
    input  logic                                 scl_b_in,
    output logic                                 sda_a_rel,
    output logic                                 scl_a_rel,
    output logic                                 sda_b_rel,
    output logic                                 scl_b_rel,
    input  logic                                 host_cyc,
    input  logic                                 host_stb,
    input  logic                                 host_we,
    input  logic [bridge_pkg::ram_addr_bits-1:0] host_adr,
    input  logic [bridge_pkg::wb_data_bits-1:0]  host_dat_w,
    output logic [bridge_pkg::wb_data_bits-1:0]  host_dat_r,
    output logic                                 host_ack
);
    import bridge_pkg::*;

    // side a as the wire sees it, own pad plus what is mirrored from b
    wire sda_mon = sda_a_in & sda_a_rel;
    wire scl_mon = scl_a_in & scl_a_rel;

    logic                     m0_cyc, m0_stb, m0_we, m0_ack;
    logic [ram_addr_bits-1:0] m0_adr;
    logic [wb_data_bits-1:0]  m0_dat_w;
    logic                     s_cyc, s_stb, s_we, s_ack;
    logic [ram_addr_bits-1:0] s_adr;
    logic [wb_data_bits-1:0]  s_dat_w, s_dat_r;

    i2c_bus_bridge i2c_bus_bridge_i
    (
        .clk(clk), .arst_n(arst_n),
        .sda_a_in(sda_a_in), .scl_a_in(scl_a_in),
        .sda_b_in(sda_b_in), .scl_b_in(scl_b_in),
        .sda_a_rel(sda_a_rel), .scl_a_rel(scl_a_rel),
        .sda_b_rel(sda_b_rel), .scl_b_rel(scl_b_rel)
    );

    i2c_bus_monitor i2c_bus_monitor_i
    (
        .clk(clk), .arst_n(arst_n),
        .sda_in(sda_mon), .scl_in(scl_mon),
        .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_we(m0_we),
        .wb_adr(m0_adr), .wb_dat_w(m0_dat_w), .wb_ack(m0_ack)
    );

    // m0 = monitor, m1 = host
    wb_arbiter wb_arbiter_i
    (
        .clk(clk), .arst_n(arst_n),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w), .m0_dat_r(), .m0_ack(m0_ack),
        .m1_cyc(host_cyc), .m1_stb(host_stb), .m1_we(host_we), .m1_adr(host_adr),
        .m1_dat_w(host_dat_w), .m1_dat_r(host_dat_r), .m1_ack(host_ack),
        .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
        .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
    );

    event_ram event_ram_i
    (
        .clk(clk), .arst_n(arst_n),
        .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
        .dat_w(s_dat_w), .dat_r(s_dat_r), .ack(s_ack)
    );

endmodule

// File: sim/i2c_segment_model.sv
`timescale 1ns/100ps

module i2c_segment_model
(
    input  logic ctl_sda,       // controller on side a, 0 = pull low
    input  logic ctl_scl,
    input  logic tgt_sda,       // target on side b
    input  logic tgt_scl,       // target never stretches here
    input  logic sda_a_rel,     // repeater drivers, 1 = released
    input  logic scl_a_rel,
    input  logic sda_b_rel,
    input  logic scl_b_rel,
    output logic sda_a,         // resolved wire levels
    output logic scl_a,
    output logic sda_b,
    output logic scl_b
);

    // pull-ups on every wire, any low driver wins
    assign sda_a = ctl_sda & sda_a_rel;
    assign scl_a = ctl_scl & scl_a_rel;

    // side b only sees the target and the mirror
    assign sda_b = tgt_sda & sda_b_rel;
    assign scl_b = tgt_scl & scl_b_rel;

endmodule

// File: sim/tb_i2c_bridge_top.sv
`timescale 1ns/100ps

module tb_i2c_bridge_top;
    import bridge_pkg::*;

    localparam int q_cycles    = 40;                        // one fifth of an scl bit
    localparam int xfer_cycles = 56 * q_cycles;             // start, 9 bits, stop
    localparam int ack_wait    = 50;                        // host bus handshake limit
    localparam int test_cycles = 4 + 20 * (tick_div + 1) + 2 * xfer_cycles + 12 * ack_wait;
    localparam int cycle_limit = 4 * test_cycles;

    logic                     clk;
    logic                     arst_n;
    logic                     ctl_sda;
    logic                     ctl_scl;
    logic                     tgt_sda;
    logic                     tgt_scl;
    logic                     sda_a;
    logic                     scl_a;
    logic                     sda_b;
    logic                     scl_b;
    logic                     sda_a_rel;
    logic                     scl_a_rel;
    logic                     sda_b_rel;
    logic                     scl_b_rel;
    logic                     host_cyc;
    logic                     host_stb;
    logic                     host_we;
    logic [ram_addr_bits-1:0] host_adr;
    logic [wb_data_bits-1:0]  host_dat_w;
    logic [wb_data_bits-1:0]  host_dat_r;
    logic                     host_ack;
    logic [31:0]              lfsr;
    logic [wb_data_bits-1:0]  host_words [3];   // written while the log runs
    int                       err_cnt  = 0;
    int                       fail_cnt = 0;
    int                       cyc_cnt  = 0;

    always #20 clk = ~clk;

    i2c_bridge_top i2c_bridge_top_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .sda_a_in   (sda_a),
        .scl_a_in   (scl_a),
        .sda_b_in   (sda_b),
        .scl_b_in   (scl_b),
        .sda_a_rel  (sda_a_rel),
        .scl_a_rel  (scl_a_rel),
        .sda_b_rel  (sda_b_rel),
        .scl_b_rel  (scl_b_rel),
        .host_cyc   (host_cyc),
        .host_stb   (host_stb),
        .host_we    (host_we),
        .host_adr   (host_adr),
        .host_dat_w (host_dat_w),
        .host_dat_r (host_dat_r),
        .host_ack   (host_ack)
    );

    i2c_segment_model segment_model_i
    (
        .ctl_sda   (ctl_sda),
        .ctl_scl   (ctl_scl),
        .tgt_sda   (tgt_sda),
        .tgt_scl   (tgt_scl),
        .sda_a_rel (sda_a_rel),
        .scl_a_rel (scl_a_rel),
        .sda_b_rel (sda_b_rel),
        .scl_b_rel (scl_b_rel),
        .sda_a     (sda_a),
        .scl_a     (scl_a),
        .sda_b     (sda_b),
        .scl_b     (scl_b)
    );

    task automatic log_error(input string msg);
        err_cnt++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        fail_cnt++;
        $display("%s", msg);
    endtask

    // bridge line checks on every clock
    // a mirrored low may only start from a real driver low on the other side
    assert property (@(posedge clk) disable iff (!arst_n) $fell(sda_b_rel) |-> !$past(ctl_sda))
    else log_error("sda_b_rel pulled low with no controller low on side a");
    assert property (@(posedge clk) disable iff (!arst_n) $fell(sda_a_rel) |-> !$past(tgt_sda))
    else log_error("sda_a_rel pulled low with no target low on side b");
    assert property (@(posedge clk) disable iff (!arst_n) scl_a_rel)
    else log_error("scl_a_rel low although side b never drives scl");
    assert property (@(posedge clk) disable iff (!arst_n) host_ack |-> host_cyc && host_stb)
    else log_error("host_ack outside a host cycle");
    assert property (@(posedge clk) disable iff (!arst_n) host_ack |=> !host_ack)
    else log_error("host_ack high for more than one cycle");

    // run length limit
    always @(posedge clk)
    begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= cycle_limit)
        begin
            $display("timeout, run stopped after %0d cycles", cyc_cnt);
            $display("value errors: %0d, other failures: %0d", err_cnt, fail_cnt);
            $display("tests failed");
            $finish;
        end
    end

    // inputs always change 2 ns after the edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // kind, ack, overflow (always clear here), seq, data
    function automatic logic [15:0] make_rec(input event_kind_t kind, input logic ack,
                                             input logic [3:0] seq, input logic [7:0] data);
        return {kind, ack, 1'b0, seq, data};
    endfunction

    task automatic wb_access(input logic we, input logic [ram_addr_bits-1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
        int n;
        n          = 0;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_dat_w = wdat;
        step(1);
        while (!host_ack && n < ack_wait)
        begin
            step(1);
            n++;
        end
        rdat = host_dat_r;
        if (!host_ack)
            log_failure($sformatf("no ack from the event memory for address %0d", adr));
        step(1);            // stb held one cycle past ack
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic read_expect(input logic [ram_addr_bits-1:0] adr, input logic [15:0] exp,
                               input string what);
        logic [15:0] got;
        wb_access(1'b0, adr, 16'h0000, got);
        assert (got === exp)
        else log_error($sformatf("%s at %0d read %h, expected %h", what, adr, got, exp));
    endtask

    // wait until the monitor has written count records
    task automatic wait_records(input int count);
        int n;
        n = 0;
        while (i2c_bridge_top_i.m0_adr != ram_addr_bits'(count) && n < xfer_cycles)
        begin
            step(1);
            n++;
        end
        if (i2c_bridge_top_i.m0_adr != ram_addr_bits'(count))
            log_failure($sformatf("monitor did not reach %0d records", count));
    endtask

    task automatic check_a_to_b();
        int n;
        n       = 0;
        ctl_scl = 1'b0;     // scl low so no start is decoded
        step(3 * tick_div);
        ctl_sda = 1'b0;
        while (sda_b_rel && n < tick_div + 1)
        begin
            step(1);
            n++;
            assert (sda_a_rel) else log_error("sda_a_rel followed its own low");
        end
        assert (!sda_b_rel) else log_error("sda_b_rel not low within tick_div+1 cycles");
        step(3 * tick_div);
        assert (sda_a_rel && !sda_b_rel) else log_error("sda mirror lost while side a holds");
        ctl_sda = 1'b1;
        n       = 0;
        while (!(sda_a_rel && sda_b_rel) && n < 2 * (tick_div + 1))
        begin
            step(1);
            n++;
        end
        assert (sda_a_rel && sda_b_rel) else log_error("sda not released after side a let go");
    endtask

    task automatic check_b_to_a();
        int n;
        n = 0;
        step(3 * tick_div);         // release state back to idle
        tgt_sda = 1'b0;
        while (sda_a_rel && n < tick_div + 1)
        begin
            step(1);
            n++;
            assert (sda_b_rel) else log_error("sda_b_rel followed its own low");
        end
        assert (!sda_a_rel) else log_error("sda_a_rel not low within tick_div+1 cycles");
        tgt_sda = 1'b1;
        n       = 0;
        while (!(sda_a_rel && sda_b_rel) && n < 2 * (tick_div + 1))
        begin
            step(1);
            n++;
        end
        assert (sda_a_rel && sda_b_rel) else log_error("sda not released after side b let go");
        ctl_scl = 1'b1;
        step(3 * tick_div);
    endtask

    // sda is set early in scl low and the target lets go q_cycles after scl falls
    task automatic send_bit(input logic b, input logic ack_slot);
        ctl_sda = b;
        if (ack_slot)
            tgt_sda = 1'b0;
        step(2 * q_cycles);
        ctl_scl = 1'b1;
        step(2 * q_cycles);
        ctl_scl = 1'b0;
        step(q_cycles);
        tgt_sda = 1'b1;
    endtask

    task automatic run_xfer(input logic [7:0] data);
        int i;
        ctl_sda = 1'b0;             // start
        step(2 * q_cycles);
        ctl_scl = 1'b0;
        step(q_cycles);
        for (i = 7; i >= 0; i--)
            send_bit(data[i], 1'b0);
        send_bit(1'b1, 1'b1);       // ack from side b
        ctl_sda = 1'b0;             // stop
        step(2 * q_cycles);
        ctl_scl = 1'b1;
        step(2 * q_cycles);
        ctl_sda = 1'b1;
        step(2 * q_cycles);
    endtask

    // host hits the memory right when the monitor asks for it
    task automatic write_while_logging();
        logic [15:0] got;
        int          k;
        int          n;
        for (k = 0; k < 3; k++)
        begin
            host_words[k] = 16'(take_bits(16));
            n = 0;
            while (!i2c_bridge_top_i.m0_cyc && n < xfer_cycles)
            begin
                step(1);
                n++;
            end
            if (!i2c_bridge_top_i.m0_cyc)
                log_failure("monitor never requested the memory during the transaction");
            wb_access(1'b1, 6'(40 + k), host_words[k], got);
            read_expect(6'(40 + k), host_words[k], "host word");
        end
    endtask

    initial
    begin
        logic [7:0] byte0;
        logic [7:0] byte1;
        clk        = 1'b0;
        arst_n     = 1'b0;
        ctl_sda    = 1'b1;
        ctl_scl    = 1'b1;
        tgt_sda    = 1'b1;
        tgt_scl    = 1'b1;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        lfsr       = 32'h2d862854;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        assert (sda_a_rel && scl_a_rel && sda_b_rel && scl_b_rel && !host_ack)
        else log_error("outputs not idle after reset");

        check_a_to_b();
        check_b_to_a();

        byte0 = 8'(take_bits(8));
        run_xfer(byte0);
        wait_records(3);
        read_expect(6'd0, make_rec(ev_start, 1'b0, 4'd0, 8'h00), "start record");
        read_expect(6'd1, make_rec(ev_byte, 1'b0, 4'd1, byte0), "byte record");
        read_expect(6'd2, make_rec(ev_stop, 1'b0, 4'd2, 8'h00), "stop record");

        byte1 = 8'(take_bits(8));
        fork
            run_xfer(byte1);
            write_while_logging();
        join
        wait_records(6);
        read_expect(6'd3, make_rec(ev_start, 1'b0, 4'd3, 8'h00), "start record");
        read_expect(6'd4, make_rec(ev_byte, 1'b0, 4'd4, byte1), "byte record");
        read_expect(6'd5, make_rec(ev_stop, 1'b0, 4'd5, 8'h00), "stop record");
        read_expect(6'd40, host_words[0], "host word kept");
        read_expect(6'd41, host_words[1], "host word kept");
        read_expect(6'd42, host_words[2], "host word kept");

        $display("value errors: %0d, other failures: %0d", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: list.f
hdl/bridge_pkg.sv
hdl/i2c_line_bridge.sv
hdl/i2c_bus_bridge.sv
hdl/i2c_bus_monitor.sv
hdl/wb_arbiter.sv
hdl/event_ram.sv
hdl/i2c_bridge_top.sv
sim/i2c_segment_model.sv
sim/tb_i2c_bridge_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I2C repeater testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_i2c_bridge_top -Mdir obj_dir -o sim_tb -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
